// ==== include/keypad_defs.svh ====
/* Timing and width constants for the keypad front end and the display
   Included by the package, the RTL modules and the bench */

`ifndef KEYPAD_DEFS_SVH
`define KEYPAD_DEFS_SVH

// ==============================
// Column scan
// ==============================
`define KEYPAD_SCAN_DWELL       8   // Cycles per driven column

// ==============================
// Debounce
// ==============================
`define KEYPAD_DEBOUNCE_CYCLES  32  // Steady cycles before a key is accepted
`define KEYPAD_DEB_CNT_W        8   // Must hold KEYPAD_DEBOUNCE_CYCLES - 1

// ==============================
// Display multiplexing
// ==============================
`define KEYPAD_MUX_PERIOD       16  // Cycles each digit stays lit
`define KEYPAD_MUX_CNT_W        5   // Must hold KEYPAD_MUX_PERIOD - 1

`endif

// ==== hw/keypad_pkg.sv ====
/* Shared types for the keypad front end and display
   Referenced by scoped name from every RTL module */

`include "keypad_defs.svh"

package keypad_pkg;

    // ==============================
    // Vector types
    // ==============================

    // Hex key value 0 to F
    typedef logic [3:0] key_code_t;

    // Row or column lines, active low
    typedef logic [3:0] line_t;

    // Row or column index
    typedef logic [1:0] line_idx_t;

    // Segment pattern, bit 0 is a and bit 6 is g, active low
    typedef logic [6:0] seg_t;

    // Debounce counter
    typedef logic [`KEYPAD_DEB_CNT_W-1:0] deb_cnt_t;

    // ==============================
    // State machines
    // ==============================
    typedef enum logic [1:0] {
        IDLE,        // Nothing pressed
        DEBOUNCING,  // Waiting for the key to settle
        KEY_VALID,   // One-cycle accept
        KEY_HELD     // Accepted key still down
    } deb_state_t;

endpackage

// ==== hw/keypad_scanner.sv ====
/* Drives one keypad column low at a time and synchronizes the row inputs
   Flags a press or a same-column ghost to the debouncer, and holds on scan_stop */

`include "keypad_defs.svh"

module keypad_scanner (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::line_t     rows,              // Active low, external pull-ups
    input  logic                  scan_stop,         // Freeze on the current column
    output keypad_pkg::line_t     cols,              // One bit low at a time
    output keypad_pkg::line_t     sync_rows,         // Rows after the two-flop sync
    output keypad_pkg::line_idx_t col_idx,           // Column matching sync_rows
    output logic                  key_detected,      // Any row low
    output logic                  ghosting_detected  // More than one row low
);

    localparam int DWELL_W = (`KEYPAD_SCAN_DWELL > 1) ? $clog2(`KEYPAD_SCAN_DWELL) : 1;
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(`KEYPAD_SCAN_DWELL - 1);

    logic [DWELL_W-1:0]    dwell_cnt;   // Cycles spent on the current column
    keypad_pkg::line_idx_t drive_idx;   // Column being driven now
    keypad_pkg::line_idx_t idx_d1;      // Column index delayed with the sync stage
    keypad_pkg::line_idx_t idx_d2;
    keypad_pkg::line_t     rows_meta;   // First sync flop
    keypad_pkg::line_t     row_low;     // Active high view of sync_rows

    // ==============================
    // Column drive
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            drive_idx <= '0;                      // Column 0 out of reset
        end else if (!scan_stop) begin
            if (dwell_cnt == DWELL_LAST) begin
                dwell_cnt <= '0;
                drive_idx <= drive_idx + 2'd1;    // Wraps 3 -> 0
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    assign cols = ~(keypad_pkg::line_t'(1) << drive_idx);  // One-hot low

    // ==============================
    // Row synchronizer
    // ==============================
    // The column index rides along so the decoder sees a matching pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_meta <= '1;                      // Idle rows read high
            sync_rows <= '1;
            idx_d1    <= '0;
            idx_d2    <= '0;
        end else begin
            rows_meta <= rows;
            sync_rows <= rows_meta;
            idx_d1    <= drive_idx;
            idx_d2    <= idx_d1;
        end
    end

    assign col_idx = idx_d2;

    // ==============================
    // Press and ghost detection
    // ==============================
    assign row_low = ~sync_rows;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_detected      <= 1'b0;
            ghosting_detected <= 1'b0;
        end else begin
            key_detected      <= |row_low;
            // Clearing the lowest set bit leaves something only if two or more are set
            ghosting_detected <= |(row_low & (row_low - 4'd1));
        end
    end

    // Exactly one column pulled low, in every cycle out of reset
    a_one_col_low: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(~cols)
    ) else $error("cols not one-hot low: %b", cols);

endmodule

// ==== hw/keypad_decoder.sv ====
/* Turns the synchronized rows and the column index into a hex key code
   Phone-style layout, result registered one cycle after the inputs */

module keypad_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::line_t     sync_rows,  // Active low
    input  keypad_pkg::line_idx_t col_idx,
    output keypad_pkg::key_code_t key_code
);

    keypad_pkg::line_idx_t row_idx;   // Lowest active row
    logic                  row_hit;   // Some row is low

    // Priority encode, row 0 wins
    always_comb begin
        row_hit = 1'b1;
        if (!sync_rows[0])      row_idx = 2'd0;
        else if (!sync_rows[1]) row_idx = 2'd1;
        else if (!sync_rows[2]) row_idx = 2'd2;
        else if (!sync_rows[3]) row_idx = 2'd3;
        else begin
            row_idx = 2'd0;
            row_hit = 1'b0;
        end
    end

    // Code holds its last value when nothing is pressed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_code <= '0;
        end else if (row_hit) begin
            case ({row_idx, col_idx})
                4'b00_00: key_code <= 4'h1;
                4'b00_01: key_code <= 4'h2;
                4'b00_10: key_code <= 4'h3;
                4'b00_11: key_code <= 4'hA;
                4'b01_00: key_code <= 4'h4;
                4'b01_01: key_code <= 4'h5;
                4'b01_10: key_code <= 4'h6;
                4'b01_11: key_code <= 4'hB;
                4'b10_00: key_code <= 4'h7;
                4'b10_01: key_code <= 4'h8;
                4'b10_10: key_code <= 4'h9;
                4'b10_11: key_code <= 4'hC;
                4'b11_00: key_code <= 4'hE;   // Star position
                4'b11_01: key_code <= 4'h0;
                4'b11_10: key_code <= 4'hF;   // Hash position
                default:  key_code <= 4'hD;
            endcase
        end
    end

endmodule

// ==== hw/keypad_debouncer.sv ====
/* Accepts a key after it has stayed steady for a fixed time and pulses key_valid once
   Rejects two keys in one column and keeps the scanner parked while a key is down */

`include "keypad_defs.svh"

module keypad_debouncer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::key_code_t key_code,           // From decoder
    input  logic                  key_detected,       // From scanner, level
    input  logic                  ghosting_detected,  // From scanner, level
    output logic                  key_valid,          // One-cycle strobe
    output keypad_pkg::key_code_t debounced_key,      // Meaningful only with key_valid
    output keypad_pkg::key_code_t held_key,           // Accepted key while held
    output logic                  scan_stop           // Park the scanner
);

    localparam keypad_pkg::deb_cnt_t DEB_LAST =
        keypad_pkg::deb_cnt_t'(`KEYPAD_DEBOUNCE_CYCLES - 1);

    keypad_pkg::deb_state_t state;
    keypad_pkg::deb_cnt_t   deb_cnt;   // Steady cycles so far
    keypad_pkg::key_code_t  l_key;     // Code captured on entry to DEBOUNCING
    logic                   start;     // IDLE -> DEBOUNCING this cycle

    // Key code zero is a real key, so key_detected alone marks a press
    assign start = (state == keypad_pkg::IDLE) && key_detected && !ghosting_detected;

    // ==============================
    // State machine
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= keypad_pkg::IDLE;
            deb_cnt <= '0;
        end else begin
            case (state)
                keypad_pkg::IDLE: begin
                    if (start) begin
                        state   <= keypad_pkg::DEBOUNCING;
                        deb_cnt <= '0;
                    end
                end

                keypad_pkg::DEBOUNCING: begin
                    // Release, ghost or a changed code all count as bounce
                    if (!key_detected || ghosting_detected || key_code != l_key) begin
                        state <= keypad_pkg::IDLE;
                    end else if (deb_cnt == DEB_LAST) begin
                        state <= keypad_pkg::KEY_VALID;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end

                keypad_pkg::KEY_VALID: begin
                    state <= keypad_pkg::KEY_HELD;     // Strobe lasts one cycle
                end

                keypad_pkg::KEY_HELD: begin
                    if (!key_detected) begin
                        state <= keypad_pkg::IDLE;     // Released
                    end
                end

                default: begin
                    state <= keypad_pkg::IDLE;
                end
            endcase
        end
    end

    // Latched key, loaded only on a new press
    always_ff @(posedge clk) begin
        if (start) begin
            l_key <= key_code;
        end
    end

    // ==============================
    // Outputs decoded from state
    // ==============================
    always_comb begin
        key_valid     = 1'b0;
        debounced_key = '0;
        held_key      = '0;
        scan_stop     = 1'b0;
        case (state)
            keypad_pkg::DEBOUNCING: begin
                scan_stop = 1'b1;              // Stay on this column while settling
            end
            keypad_pkg::KEY_VALID: begin
                key_valid     = 1'b1;
                debounced_key = l_key;
                scan_stop     = 1'b1;
            end
            keypad_pkg::KEY_HELD: begin
                held_key  = l_key;
                scan_stop = 1'b1;              // Held key cannot register twice
            end
            default: begin
                scan_stop = 1'b0;
            end
        endcase
    end

    // One pulse per press, never back to back
    a_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) key_valid |=> !key_valid
    ) else $error("key_valid high two cycles in a row");

    a_valid_to_held: assert property (
        @(posedge clk) disable iff (!rst_n) key_valid |=> (state == keypad_pkg::KEY_HELD)
    ) else $error("key_valid not followed by KEY_HELD");

endmodule

// ==== hw/key_display.sv ====
/* Keeps the last two accepted keys and multiplexes them onto two seven-segment digits
   digit_en[0] shows the newest key, digit_en[1] the one before */

`include "keypad_defs.svh"

module key_display (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  key_valid,      // Strobe from debouncer
    input  keypad_pkg::key_code_t debounced_key,
    output keypad_pkg::seg_t      seg,            // Active low, bit 0 is a
    output logic [1:0]            digit_en        // Active high
);

    localparam logic [`KEYPAD_MUX_CNT_W-1:0] MUX_LAST =
        `KEYPAD_MUX_CNT_W'(`KEYPAD_MUX_PERIOD - 1);

    keypad_pkg::key_code_t         newest;    // Last accepted key
    keypad_pkg::key_code_t         older;     // The one before it
    keypad_pkg::key_code_t         shown;     // Digit value on the bus now
    logic [`KEYPAD_MUX_CNT_W-1:0]  mux_cnt;   // Cycles on the current digit

    // Hex to segments, active low, bits g..a
    function automatic keypad_pkg::seg_t hex_to_seg(input keypad_pkg::key_code_t hex);
        case (hex)
            4'h0: hex_to_seg = 7'h40;
            4'h1: hex_to_seg = 7'h79;
            4'h2: hex_to_seg = 7'h24;
            4'h3: hex_to_seg = 7'h30;
            4'h4: hex_to_seg = 7'h19;
            4'h5: hex_to_seg = 7'h12;
            4'h6: hex_to_seg = 7'h02;
            4'h7: hex_to_seg = 7'h78;
            4'h8: hex_to_seg = 7'h00;
            4'h9: hex_to_seg = 7'h10;
            4'hA: hex_to_seg = 7'h08;
            4'hB: hex_to_seg = 7'h03;   // Lower case b
            4'hC: hex_to_seg = 7'h46;
            4'hD: hex_to_seg = 7'h21;   // Lower case d
            4'hE: hex_to_seg = 7'h06;
            default: hex_to_seg = 7'h0E;
        endcase
    endfunction

    // ==============================
    // Two-key history
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            newest <= '0;
            older  <= '0;
        end else if (key_valid) begin
            older  <= newest;          // Shift down
            newest <= debounced_key;
        end
    end

    // ==============================
    // Digit multiplexer
    // ==============================
    // All digits dark out of reset, digit 0 lights the cycle after
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_en <= 2'b00;
            mux_cnt  <= '0;
        end else if (digit_en == 2'b00 || mux_cnt == MUX_LAST) begin
            mux_cnt  <= '0;
            digit_en <= (digit_en == 2'b01) ? 2'b10 : 2'b01;
        end else begin
            mux_cnt <= mux_cnt + 1'b1;
        end
    end

    assign shown = digit_en[1] ? older : newest;
    assign seg   = hex_to_seg(shown);

    // Never two digits lit together
    a_digit_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(&digit_en)
    ) else $error("both digits enabled");

endmodule

// ==== hw/keypad_display_top.sv ====
/* Keypad front end top level, scanner to decoder to debouncer to display
   Rows come from the matrix with pull-ups, cols and segments go back out */

module keypad_display_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::line_t     rows,           // Active low
    output keypad_pkg::line_t     cols,           // One column low
    output keypad_pkg::seg_t      seg,            // Active low
    output logic [1:0]            digit_en,
    output logic                  key_valid,      // One-cycle strobe
    output keypad_pkg::key_code_t debounced_key,
    output keypad_pkg::key_code_t held_key
);

    keypad_pkg::line_t     sync_rows;
    keypad_pkg::line_idx_t col_idx;
    keypad_pkg::key_code_t key_code;
    logic                  key_detected;
    logic                  ghosting_detected;
    logic                  scan_stop;           // Debouncer back to scanner

    keypad_scanner u_scanner (
        .clk               (clk),
        .rst_n             (rst_n),
        .rows              (rows),
        .scan_stop         (scan_stop),
        .cols              (cols),
        .sync_rows         (sync_rows),
        .col_idx           (col_idx),
        .key_detected      (key_detected),
        .ghosting_detected (ghosting_detected)
    );

    keypad_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .sync_rows (sync_rows),
        .col_idx   (col_idx),
        .key_code  (key_code)
    );

    keypad_debouncer u_debouncer (
        .clk               (clk),
        .rst_n             (rst_n),
        .key_code          (key_code),
        .key_detected      (key_detected),
        .ghosting_detected (ghosting_detected),
        .key_valid         (key_valid),
        .debounced_key     (debounced_key),
        .held_key          (held_key),
        .scan_stop         (scan_stop)
    );

    key_display u_display (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_valid     (key_valid),
        .debounced_key (debounced_key),
        .seg           (seg),
        .digit_en      (digit_en)
    );

endmodule

// ==== bench/keypad_matrix_model.sv ====
/* Behavioral 4x4 keypad matrix for the testbench
   Pulls a row low when a pressed key sits in the driven column, with optional contact bounce */

module keypad_matrix_model (
    input  logic              clk,
    input  keypad_pkg::line_t cols,        // Active low column drive from the DUT
    input  logic [15:0]       press_mask,  // Bit row*4+col set for a pressed key
    input  logic              bounce_en,   // Pressed contacts chatter while set
    output keypad_pkg::line_t rows         // Active low, pull-ups when open
);
    timeunit 1ns;
    timeprecision 100ps;

    int          seed = 32'h7b15;
    logic [15:0] contact_ok;   // Per key, contact currently closed
    logic [15:0] closed;       // Pressed and making contact

    initial contact_ok = '1;

    // ==============================
    // Contact bounce
    // ==============================
    always @(posedge clk) begin
        if (bounce_en) begin
            contact_ok <= 16'($random(seed));   // Fresh random chatter each cycle
        end else begin
            contact_ok <= '1;
        end
    end

    assign closed = press_mask & contact_ok;

    // ==============================
    // Row read-back
    // ==============================
    // Open rows float high, a closed key shorts its row to a low column
    always_comb begin
        rows = '1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (closed[r*4 + c] && !cols[c]) begin
                    rows[r] = 1'b0;
                end
            end
        end
    end

endmodule

// ==== bench/tb_keypad_display_top.sv ====
/* Testbench for the keypad display top level, random presses from a fixed seed
   Clean, bouncing and ghosting presses are checked against a layout and history model */

`include "keypad_defs.svh"

module tb_keypad_display_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  rst_n;
    keypad_pkg::line_t     rows;
    keypad_pkg::line_t     cols;
    keypad_pkg::seg_t      seg;
    logic [1:0]            digit_en;
    logic                  key_valid;
    keypad_pkg::key_code_t debounced_key;
    keypad_pkg::key_code_t held_key;
    logic [15:0]           press_mask;           // Keys held down, bit row*4+col
    logic                  bounce_en;

    int         seed       = 32'h7b15;
    int         value_errs = 0;
    int         other_errs = 0;
    int         pulse_cnt  = 0;                  // key_valid pulses seen so far
    logic [3:0] exp_key    = 4'h0;               // Key expected on the next pulse
    logic       check_held = 1'b0;               // held_key must match exp_key
    logic [3:0] mon_new    = 4'h0;               // Model history, newest
    logic [3:0] mon_old    = 4'h0;               // Model history, older
    logic [1:0] prev_en    = 2'b00;
    logic [1:0] last_lit   = 2'b00;
    int         run_len    = 0;                  // Cycles on the current digit

    // Phone layout, one row per entry, column 0 in the top nibble
    localparam logic [15:0] ROW_KEYS [4] = '{16'h123A, 16'h456B, 16'h789C, 16'hE0FD};
    // Active high g..a patterns, digit F first down to digit 0
    localparam logic [111:0] SEG_ON = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F,
                                       7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B,
                                       7'h06, 7'h3F};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                   // 100 MHz
    end

    keypad_display_top i_dut (
        .clk(clk), .rst_n(rst_n), .rows(rows), .cols(cols), .seg(seg), .digit_en(digit_en),
        .key_valid(key_valid), .debounced_key(debounced_key), .held_key(held_key)
    );

    keypad_matrix_model u_matrix (
        .clk(clk), .cols(cols), .press_mask(press_mask), .bounce_en(bounce_en), .rows(rows)
    );

    function automatic logic [3:0] layout_key(input int r, input int c);
        layout_key = ROW_KEYS[r][15 - 4*c -: 4];
    endfunction

    function automatic keypad_pkg::seg_t seg_of(input logic [3:0] k);
        seg_of = ~SEG_ON[k*7 +: 7];              // Display is active low
    endfunction

    function automatic int urand(input int n);
        urand = $unsigned($random(seed)) % n;
    endfunction

    task automatic report_mismatch(input string name, input int expv, input int gotv);
        value_errs++;
        $display("[FAIL] t=%0d ns %s expected %0h got %0h", $time, name, expv, gotv);
    endtask

    task automatic report_problem(input string msg);
        other_errs++;
        $display("Error at t=%0d ns: %s", $time, msg);
    endtask

    // ==============================
    // Output monitor
    // ==============================
    always @(negedge clk) begin
        if (rst_n) begin
            assert (digit_en != 2'b11) else report_problem("both digits enabled together");
            if (digit_en == 2'b01) begin
                assert (seg == seg_of(mon_new)) else report_mismatch("seg", seg_of(mon_new), seg);
            end
            if (digit_en == 2'b10) begin
                assert (seg == seg_of(mon_old)) else report_mismatch("seg", seg_of(mon_old), seg);
            end
            if (digit_en != prev_en) begin
                if (prev_en != 2'b00) begin
                    assert (run_len == `KEYPAD_MUX_PERIOD)
                        else report_mismatch("digit_en dwell", `KEYPAD_MUX_PERIOD, run_len);
                end
                if (digit_en != 2'b00 && last_lit != 2'b00) begin
                    assert (digit_en != last_lit) else report_problem("digit_en did not alternate");
                end
                run_len = 1;
            end else begin
                run_len++;
            end
            if (digit_en != 2'b00) last_lit = digit_en;
            prev_en = digit_en;
            if (key_valid) begin
                pulse_cnt++;
                assert (debounced_key == exp_key)
                    else report_mismatch("debounced_key", exp_key, debounced_key);
                mon_old = mon_new;               // History shifts on each accept
                mon_new = exp_key;
            end
            if (check_held) begin
                assert (held_key == exp_key) else report_mismatch("held_key", exp_key, held_key);
            end
        end
    end

    // ==============================
    // Wait loops, each with a limit
    // ==============================
    task automatic wait_for_pulse(input int base, input int limit, output logic ok);
        int n;
        n = 0;
        while (pulse_cnt == base && n < limit) begin
            @(posedge clk);
            n++;
        end
        ok = (pulse_cnt != base);
    endtask

    // Scanner moves again only once the debouncer is back in IDLE
    task automatic wait_scan_resume();
        keypad_pkg::line_t start;
        int                n;
        @(negedge clk);
        start = cols;
        n = 0;
        while (cols == start && n < 100) begin
            @(negedge clk);
            n++;
        end
        assert (cols != start) else report_problem("scanner did not resume after release");
    endtask

    task automatic wait_for_digit(input logic [1:0] want, output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (digit_en != want && n < 4*`KEYPAD_MUX_PERIOD) begin
            @(negedge clk);
            n++;
        end
        ok = (digit_en == want);
    endtask

    // ==============================
    // Press sequences
    // ==============================
    task automatic press_key(input int idx, input int press_bounce, input int release_bounce);
        int   base;
        int   hold;
        logic got;
        base    = pulse_cnt;
        exp_key = layout_key(idx / 4, idx % 4);
        hold    = 20 + urand(40);
        @(posedge clk);
        press_mask <= 16'd1 << idx;
        bounce_en  <= (press_bounce > 0);
        if (press_bounce > 0) begin
            repeat (press_bounce) @(posedge clk);
            bounce_en <= 1'b0;                   // Contact settles, key stays down
        end
        wait_for_pulse(base, 600, got);
        assert (got) else report_problem($sformatf("no key_valid for key index %0d", idx));
        if (got) begin
            check_held = 1'b1;
            repeat (hold) @(posedge clk);
            check_held = 1'b0;
        end
        if (release_bounce > 0) begin
            bounce_en <= 1'b1;
            repeat (release_bounce) @(posedge clk);
        end
        press_mask <= '0;
        bounce_en  <= 1'b0;
        wait_scan_resume();
        assert (pulse_cnt == base + 1) else report_mismatch("key_valid pulses", base + 1, pulse_cnt);
    endtask

    // Two keys in one column must never be accepted
    task automatic press_ghost();
        int   col;
        int   r1;
        int   r2;
        int   base;
        logic got;
        col  = urand(4);
        r1   = urand(4);
        r2   = (r1 + 1 + urand(3)) % 4;
        base = pulse_cnt;
        @(posedge clk);
        press_mask <= (16'd1 << (r1*4 + col)) | (16'd1 << (r2*4 + col));
        wait_for_pulse(base, 8*`KEYPAD_DEBOUNCE_CYCLES, got);
        assert (!got) else report_mismatch("key_valid pulses", base, pulse_cnt);
        @(posedge clk);
        press_mask <= '0;
        wait_scan_resume();
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin : stimulus
        int   pb;
        int   rb;
        logic ok;
        rst_n      = 1'b0;
        press_mask = '0;
        bounce_en  = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        assert (key_valid == 1'b0) else report_mismatch("key_valid", 0, key_valid);
        assert (digit_en == 2'b00) else report_mismatch("digit_en", 0, digit_en);
        assert (cols == 4'b1110) else report_mismatch("cols", 4'b1110, cols);
        assert (held_key == 4'h0) else report_mismatch("held_key", 0, held_key);
        assert (seg == seg_of(4'h0)) else report_mismatch("seg", seg_of(4'h0), seg);
        @(posedge clk);
        rst_n <= 1'b1;                           // 16 cycles of reset

        for (int i = 0; i < 4; i++) begin
            press_key(urand(16), 0, 0);          // Clean press and release
        end
        for (int i = 0; i < 4; i++) begin
            pb = 5 + urand(26);                  // Shorter than the debounce time
            rb = 5 + urand(20);
            press_key(urand(16), pb, rb);
        end
        for (int i = 0; i < 3; i++) begin
            press_ghost();
        end
        for (int i = 0; i < 6; i++) begin
            press_key(urand(16), 0, 0);
        end

        // Both digits after the sequence
        wait_for_digit(2'b01, ok);
        assert (ok) else report_problem("newest digit never enabled");
        assert (seg == seg_of(mon_new)) else report_mismatch("seg", seg_of(mon_new), seg);
        wait_for_digit(2'b10, ok);
        assert (ok) else report_problem("older digit never enabled");
        assert (seg == seg_of(mon_old)) else report_mismatch("seg", seg_of(mon_old), seg);

        $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== keypad_display_top.f ====
+incdir+include
hw/keypad_pkg.sv
hw/keypad_scanner.sv
hw/keypad_decoder.sv
hw/keypad_debouncer.sv
hw/key_display.sv
hw/keypad_display_top.sv
bench/keypad_matrix_model.sv
bench/tb_keypad_display_top.sv
